// ==== verilog/dm_pkg.sv ====
`default_nettype none

package dm_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int unsigned NrHarts      = 4;
  localparam int unsigned HartSelLen   = 2;
  localparam int unsigned DataCount    = 2;
  localparam int unsigned DmiAddrWidth = 7;

  // register map, data1 sits right after data0
  localparam logic [DmiAddrWidth-1:0] AddrData0        = 7'h04;
  localparam logic [DmiAddrWidth-1:0] AddrDmControl    = 7'h10;
  localparam logic [DmiAddrWidth-1:0] AddrDmStatus     = 7'h11;
  localparam logic [DmiAddrWidth-1:0] AddrAbstractCs   = 7'h16;
  localparam logic [DmiAddrWidth-1:0] AddrCommand      = 7'h17;
  localparam logic [DmiAddrWidth-1:0] AddrAbstractAuto = 7'h18;
  localparam logic [DmiAddrWidth-1:0] AddrHaltSum0     = 7'h40;

  // debug spec 0.13
  localparam logic [3:0] DbgVersion = 4'd2;

  // --------------------------------------------------
  // codes
  // --------------------------------------------------
  localparam logic [1:0] DmiOpNop   = 2'd0;
  localparam logic [1:0] DmiOpRead  = 2'd1;
  localparam logic [1:0] DmiOpWrite = 2'd2;

  // higher cmderr codes come from the hart side unchanged
  localparam logic [2:0] CmdErrNone = 3'd0;
  localparam logic [2:0] CmdErrBusy = 3'd1;

  // one dmi word, seen raw, as dmcontrol or as abstractcs
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic       haltreq;
      logic       resumereq;
      logic       hartreset;
      logic       ackhavereset;
      logic       zero1;
      logic       hasel;
      logic [9:0] hartsello;
      logic [13:0] zero0;
      logic       ndmreset;
      logic       dmactive;
    } dmcontrol;
    struct packed {
      logic [2:0]  zero3;
      logic [4:0]  progbufsize;
      logic [10:0] zero2;
      logic        busy;
      logic        zero1;
      logic [2:0]  cmderr;
      logic [3:0]  zero0;
      logic [3:0]  datacount;
    } abstractcs;
  } dmi_word_u;

endpackage

`default_nettype wire

// ==== verilog/dm_csr_if.sv ====
`default_nettype none

// one decoded register access, front end to register block
interface dm_csr_if import dm_pkg::*; ();

  logic                    sel;
  logic                    we;
  logic [DmiAddrWidth-1:0] addr;
  logic [31:0]             wdata;
  logic [31:0]             rdata;

  modport front (
    output sel,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport regs (
    input  sel,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// ==== verilog/dm_dmi_front.sv ====
`default_nettype none

module dm_dmi_front import dm_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    dmi_req_valid_i,
  output logic                    dmi_req_ready_o,
  input  logic [DmiAddrWidth-1:0] dmi_req_addr_i,
  input  logic [1:0]              dmi_req_op_i,
  input  logic [31:0]             dmi_req_data_i,
  output logic                    dmi_resp_valid_o,
  input  logic                    dmi_resp_ready_i,
  output logic [31:0]             dmi_resp_data_o,
  dm_csr_if.front                 hart_bus,
  dm_csr_if.front                 cmd_bus
);

  logic        accept;
  logic        req_rd;
  logic        req_wr;
  logic        hart_hit;
  logic        cmd_hit;
  logic [31:0] resp_word;
  logic [31:0] fifo_q [2];
  logic        wr_ptr_q;
  logic        rd_ptr_q;
  logic [1:0]  count_q;
  logic        push;
  logic        pop;
  logic        full;
  logic        empty;

  assign accept = dmi_req_valid_i & dmi_req_ready_o;

  always_comb begin
    req_rd = 1'b0;
    req_wr = 1'b0;
    case (dmi_req_op_i)
      DmiOpRead:  req_rd = 1'b1;
      DmiOpWrite: req_wr = 1'b1;
      // answered with zero, no register touched
      DmiOpNop:   ;
      default:    ;
    endcase
  end

  // block ranges
  assign hart_hit = ((dmi_req_addr_i >= AddrDmControl) && (dmi_req_addr_i <= AddrDmStatus))
                    || (dmi_req_addr_i == AddrHaltSum0);
  assign cmd_hit  = ((dmi_req_addr_i >= AddrData0) && (dmi_req_addr_i < AddrData0 + DataCount))
                    || ((dmi_req_addr_i >= AddrAbstractCs) && (dmi_req_addr_i <= AddrAbstractAuto));

  assign hart_bus.sel   = accept & (req_rd | req_wr) & hart_hit;
  assign hart_bus.we    = req_wr;
  assign hart_bus.addr  = dmi_req_addr_i;
  assign hart_bus.wdata = dmi_req_data_i;

  assign cmd_bus.sel   = accept & (req_rd | req_wr) & cmd_hit;
  assign cmd_bus.we    = req_wr;
  assign cmd_bus.addr  = dmi_req_addr_i;
  assign cmd_bus.wdata = dmi_req_data_i;

  // only reads carry data back
  always_comb begin
    resp_word = '0;
    if (req_rd) begin
      if (hart_hit) begin
        resp_word = hart_bus.rdata;
      end else if (cmd_hit) begin
        resp_word = cmd_bus.rdata;
      end
    end
  end

  // --------------------------------------------------
  // response fifo, two entries
  // --------------------------------------------------
  assign full  = (count_q == 2'd2);
  assign empty = (count_q == 2'd0);
  assign push  = accept;
  assign pop   = dmi_resp_valid_o & dmi_resp_ready_i;

  assign dmi_req_ready_o  = ~full;
  assign dmi_resp_valid_o = ~empty;
  assign dmi_resp_data_o  = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= resp_word;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dm_hart_ctrl.sv ====
`default_nettype none

module dm_hart_ctrl import dm_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  dm_csr_if.regs             bus,
  input  logic [NrHarts-1:0] halted_i,
  input  logic [NrHarts-1:0] unavailable_i,
  input  logic [NrHarts-1:0] resumeack_i,
  output logic [NrHarts-1:0] haltreq_o,
  output logic [NrHarts-1:0] resumereq_o,
  output logic               clear_resumeack_o,
  output logic [9:0]         hartsel_o,
  output logic               ndmreset_o,
  output logic               dmactive_o
);

  dmi_word_u             dmcontrol_q;
  dmi_word_u             dmcontrol_d;
  dmi_word_u             wr_word;
  logic [NrHarts-1:0]    havereset_q;
  logic [NrHarts-1:0]    havereset_d;
  logic [HartSelLen-1:0] hart_idx;
  logic                  hart_exists;
  logic                  ctrl_we;
  logic                  sel_halted;
  logic                  sel_running;
  logic                  sel_unavail;
  logic                  sel_resumeack;
  logic                  sel_havereset;
  logic [31:0]           dmstatus;
  logic [31:0]           haltsum0;

  assign wr_word.raw = bus.wdata;
  assign ctrl_we     = bus.sel & bus.we & (bus.addr == AddrDmControl);

  assign hartsel_o   = dmcontrol_q.dmcontrol.hartsello;
  assign hart_idx    = hartsel_o[HartSelLen-1:0];
  assign hart_exists = hartsel_o < 10'(NrHarts);

  // --------------------------------------------------
  // status of the selected hart
  // --------------------------------------------------
  // unavailable wins over halted and running
  assign sel_unavail   = hart_exists & unavailable_i[hart_idx];
  assign sel_halted    = hart_exists & halted_i[hart_idx] & ~unavailable_i[hart_idx];
  assign sel_running   = hart_exists & ~halted_i[hart_idx] & ~unavailable_i[hart_idx];
  assign sel_resumeack = hart_exists & resumeack_i[hart_idx];
  assign sel_havereset = hart_exists & havereset_q[hart_idx];

  always_comb begin
    dmstatus        = '0;
    dmstatus[19:18] = {2{sel_havereset}};
    dmstatus[17:16] = {2{sel_resumeack}};
    dmstatus[15:14] = {2{~hart_exists}};
    dmstatus[13:12] = {2{sel_unavail}};
    dmstatus[11:10] = {2{sel_running}};
    dmstatus[9:8]   = {2{sel_halted}};
    // no authentication
    dmstatus[7]     = 1'b1;
    dmstatus[3:0]   = DbgVersion;
  end

  assign haltsum0 = 32'(halted_i);

  // --------------------------------------------------
  // dmcontrol and havereset
  // --------------------------------------------------
  always_comb begin
    dmcontrol_d = dmcontrol_q;
    if (ctrl_we) begin
      dmcontrol_d = wr_word;
    end
    // fields that hold no state
    dmcontrol_d.dmcontrol.hartreset    = 1'b0;
    dmcontrol_d.dmcontrol.ackhavereset = 1'b0;
    dmcontrol_d.dmcontrol.zero1        = 1'b0;
    dmcontrol_d.dmcontrol.hasel        = 1'b0;
    dmcontrol_d.dmcontrol.zero0        = '0;
    // hart took the resume
    if (dmcontrol_q.dmcontrol.resumereq && sel_resumeack) begin
      dmcontrol_d.dmcontrol.resumereq = 1'b0;
    end
    clear_resumeack_o = dmcontrol_q.dmcontrol.dmactive
                        & ~dmcontrol_q.dmcontrol.resumereq
                        & dmcontrol_d.dmcontrol.resumereq;
  end

  always_comb begin
    havereset_d = havereset_q;
    if (ctrl_we && wr_word.dmcontrol.ackhavereset && hart_exists) begin
      havereset_d[hart_idx] = 1'b0;
    end
    if (dmcontrol_q.dmcontrol.ndmreset) begin
      havereset_d = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      havereset_q <= '1;
    end else begin
      havereset_q <= havereset_d;
      if (!dmcontrol_q.dmcontrol.dmactive) begin
        // inactive, only dmactive takes a write
        dmcontrol_q.raw <= {31'b0, dmcontrol_d.dmcontrol.dmactive};
      end else begin
        dmcontrol_q <= dmcontrol_d;
      end
    end
  end

  // requests only to an existing selected hart
  always_comb begin
    haltreq_o   = '0;
    resumereq_o = '0;
    if (hart_exists) begin
      haltreq_o[hart_idx]   = dmcontrol_q.dmcontrol.haltreq;
      resumereq_o[hart_idx] = dmcontrol_q.dmcontrol.resumereq;
    end
  end

  assign ndmreset_o = dmcontrol_q.dmcontrol.ndmreset;
  assign dmactive_o = dmcontrol_q.dmcontrol.dmactive;

  always_comb begin
    case (bus.addr)
      AddrDmControl: bus.rdata = dmcontrol_q.raw;
      AddrDmStatus:  bus.rdata = dmstatus;
      AddrHaltSum0:  bus.rdata = haltsum0;
      default:       bus.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/dm_abstract_cmd.sv ====
`default_nettype none

module dm_abstract_cmd import dm_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  dm_csr_if.regs                     bus,
  input  logic                       dmactive_i,
  input  logic                       cmdbusy_i,
  input  logic                       cmderror_valid_i,
  input  logic [2:0]                 cmderror_i,
  output logic                       cmd_valid_o,
  output logic [31:0]                cmd_o,
  output logic [DataCount-1:0][31:0] data_o,
  input  logic [DataCount-1:0][31:0] data_i,
  input  logic                       data_valid_i
);

  logic [2:0]                 cmderr_q;
  logic [2:0]                 cmderr_d;
  logic [DataCount-1:0]       autoexec_q;
  logic [DataCount-1:0]       autoexec_d;
  logic                       cmd_valid_q;
  logic                       cmd_valid_d;
  logic [31:0]                command_q;
  logic [31:0]                command_d;
  logic [DataCount-1:0][31:0] data_q;
  logic [DataCount-1:0][31:0] data_d;
  logic [DmiAddrWidth-1:0]    data_off;
  logic                       is_data;
  logic [$clog2(DataCount)-1:0] data_idx;
  logic                       busy_err;
  dmi_word_u                  wr_word;
  dmi_word_u                  cs_word;

  assign wr_word.raw = bus.wdata;
  assign data_off    = bus.addr - AddrData0;
  assign is_data     = data_off < DataCount;
  assign data_idx    = data_off[$clog2(DataCount)-1:0];

  // --------------------------------------------------
  // next state
  // --------------------------------------------------
  always_comb begin
    cmderr_d    = cmderr_q;
    autoexec_d  = autoexec_q;
    command_d   = command_q;
    data_d      = data_q;
    cmd_valid_d = 1'b0;
    busy_err    = 1'b0;

    if (bus.sel && is_data) begin
      if (!cmdbusy_i) begin
        if (bus.we) begin
          data_d[data_idx] = bus.wdata;
        end
        // reads and writes both retrigger
        cmd_valid_d = autoexec_q[data_idx];
      end else begin
        busy_err = bus.we;
      end
    end else if (bus.sel && bus.we) begin
      case (bus.addr)
        AddrCommand: begin
          if (!cmdbusy_i) begin
            command_d   = bus.wdata;
            cmd_valid_d = 1'b1;
          end else begin
            busy_err = 1'b1;
          end
        end
        AddrAbstractAuto: begin
          if (!cmdbusy_i) begin
            autoexec_d = bus.wdata[DataCount-1:0];
          end else begin
            busy_err = 1'b1;
          end
        end
        AddrAbstractCs: begin
          // write one to clear
          if (!cmdbusy_i) begin
            cmderr_d = cmderr_q & ~wr_word.abstractcs.cmderr;
          end
        end
        default: ;
      endcase
    end

    // first error sticks
    if (busy_err && (cmderr_q == CmdErrNone)) begin
      cmderr_d = CmdErrBusy;
    end
    // hart side has priority
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= CmdErrNone;
      autoexec_q  <= '0;
      cmd_valid_q <= 1'b0;
    end else if (!dmactive_i) begin
      cmderr_q    <= CmdErrNone;
      autoexec_q  <= '0;
      cmd_valid_q <= 1'b0;
    end else begin
      cmderr_q    <= cmderr_d;
      autoexec_q  <= autoexec_d;
      cmd_valid_q <= cmd_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!dmactive_i) begin
      command_q <= '0;
      data_q    <= '0;
    end else begin
      command_q <= command_d;
      data_q    <= data_d;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;

  // --------------------------------------------------
  // read back
  // --------------------------------------------------
  always_comb begin
    cs_word                      = '0;
    cs_word.abstractcs.datacount = 4'(DataCount);
    cs_word.abstractcs.busy      = cmdbusy_i;
    cs_word.abstractcs.cmderr    = cmderr_q;
  end

  always_comb begin
    if (is_data) begin
      bus.rdata = data_q[data_idx];
    end else begin
      case (bus.addr)
        AddrAbstractCs:   bus.rdata = cs_word.raw;
        AddrAbstractAuto: bus.rdata = 32'(autoexec_q);
        // command reads as zero
        default:          bus.rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dm_top.sv ====
`default_nettype none

module dm_top import dm_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // dmi
  input  logic                       dmi_req_valid_i,
  output logic                       dmi_req_ready_o,
  input  logic [DmiAddrWidth-1:0]    dmi_req_addr_i,
  input  logic [1:0]                 dmi_req_op_i,
  input  logic [31:0]                dmi_req_data_i,
  output logic                       dmi_resp_valid_o,
  input  logic                       dmi_resp_ready_i,
  output logic [31:0]                dmi_resp_data_o,
  // hart status and control
  input  logic [NrHarts-1:0]         halted_i,
  input  logic [NrHarts-1:0]         unavailable_i,
  input  logic [NrHarts-1:0]         resumeack_i,
  output logic [NrHarts-1:0]         haltreq_o,
  output logic [NrHarts-1:0]         resumereq_o,
  output logic                       clear_resumeack_o,
  output logic [9:0]                 hartsel_o,
  output logic                       ndmreset_o,
  output logic                       dmactive_o,
  // abstract command
  output logic                       cmd_valid_o,
  output logic [31:0]                cmd_o,
  input  logic                       cmdbusy_i,
  input  logic                       cmderror_valid_i,
  input  logic [2:0]                 cmderror_i,
  output logic [DataCount-1:0][31:0] data_o,
  input  logic [DataCount-1:0][31:0] data_i,
  input  logic                       data_valid_i
);

  dm_csr_if hart_bus ();
  dm_csr_if cmd_bus ();

  dm_dmi_front i_dmi_front (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dmi_req_valid_i  (dmi_req_valid_i),
    .dmi_req_ready_o  (dmi_req_ready_o),
    .dmi_req_addr_i   (dmi_req_addr_i),
    .dmi_req_op_i     (dmi_req_op_i),
    .dmi_req_data_i   (dmi_req_data_i),
    .dmi_resp_valid_o (dmi_resp_valid_o),
    .dmi_resp_ready_i (dmi_resp_ready_i),
    .dmi_resp_data_o  (dmi_resp_data_o),
    .hart_bus         (hart_bus.front),
    .cmd_bus          (cmd_bus.front)
  );

  dm_hart_ctrl i_hart_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .bus               (hart_bus.regs),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o),
    .hartsel_o         (hartsel_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o)
  );

  dm_abstract_cmd i_abstract_cmd (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bus              (cmd_bus.regs),
    .dmactive_i       (dmactive_o),
    .cmdbusy_i        (cmdbusy_i),
    .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i       (cmderror_i),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_o            (cmd_o),
    .data_o           (data_o),
    .data_i           (data_i),
    .data_valid_i     (data_valid_i)
  );

endmodule

`default_nettype wire

// ==== tb/dm_top_sva.sv ====
`default_nettype none

module dm_top_sva import dm_pkg::*; (
  input logic               clk_i,
  input logic               rst_ni,
  input logic [NrHarts-1:0] haltreq_o,
  input logic [NrHarts-1:0] resumereq_o,
  input logic               dmi_req_ready_o,
  input logic               dmi_resp_valid_o,
  input logic               dmactive_o
);

  // failed assertions so far
  int fail_count = 0;

  // at most one hart gets a request
  req_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(haltreq_o) && $onehot0(resumereq_o))
    else begin
      $error("more than one hart requested at once");
      fail_count++;
    end

  // ready only drops with a full fifo
  ready_low_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !dmi_req_ready_o |-> dmi_resp_valid_o)
    else begin
      $error("request ready low while no response is pending");
      fail_count++;
    end

  inactive_halt_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !dmactive_o |=> (haltreq_o == '0))
    else begin
      $error("halt request survived an inactive debug module");
      fail_count++;
    end

endmodule

bind dm_top dm_top_sva i_sva (.*);

`default_nettype wire

// ==== tb/tb_dm_top.sv ====
`default_nettype none

module tb_dm_top import dm_pkg::*; ();

  localparam int WaitLimit = 50;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       dmi_req_valid_i;
  logic                       dmi_req_ready_o;
  logic [DmiAddrWidth-1:0]    dmi_req_addr_i;
  logic [1:0]                 dmi_req_op_i;
  logic [31:0]                dmi_req_data_i;
  logic                       dmi_resp_valid_o;
  logic                       dmi_resp_ready_i;
  logic [31:0]                dmi_resp_data_o;
  logic [NrHarts-1:0]         halted_i;
  logic [NrHarts-1:0]         unavailable_i;
  logic [NrHarts-1:0]         resumeack_i;
  logic [NrHarts-1:0]         haltreq_o;
  logic [NrHarts-1:0]         resumereq_o;
  logic                       clear_resumeack_o;
  logic [9:0]                 hartsel_o;
  logic                       ndmreset_o;
  logic                       dmactive_o;
  logic                       cmd_valid_o;
  logic [31:0]                cmd_o;
  logic                       cmdbusy_i;
  logic                       cmderror_valid_i;
  logic [2:0]                 cmderror_i;
  logic [DataCount-1:0][31:0] data_o;
  logic [DataCount-1:0][31:0] data_i;
  logic                       data_valid_i;

  int            errors;
  int            checks;
  int            clr_pulses;
  int            cmd_pulses;
  string         name_q[$];
  logic [31:0]   got_q[$];
  logic [31:0]   exp_q[$];
  logic [31:0]   resp_q[$];

  // expected register state
  logic [9:0]         m_hartsel;
  logic [NrHarts-1:0] m_havereset;
  logic               m_haltreq;
  logic               m_resumereq;

  dm_top i_dut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // pulses counted mid cycle
  always @(negedge clk_i) begin
    if (clear_resumeack_o) clr_pulses++;
    if (cmd_valid_o) cmd_pulses++;
  end

  initial begin : compare_proc
    string       name;
    logic [31:0] got;
    logic [31:0] exp;
    forever begin
      @(negedge clk_i);
      while (got_q.size() > 0) begin
        name = name_q.pop_front();
        got  = got_q.pop_front();
        exp  = exp_q.pop_front();
        checks++;
        if (got !== exp) begin
          errors++;
          $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
      end
    end
  end

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic void ref_model(
    input  logic [9:0]         hartsel,
    input  logic [NrHarts-1:0] halted,
    input  logic [NrHarts-1:0] unavail,
    input  logic [NrHarts-1:0] resumeack,
    input  logic [NrHarts-1:0] havereset,
    input  logic               haltreq,
    input  logic               resumereq,
    output logic [31:0]        dmstatus,
    output logic [31:0]        haltsum0,
    output logic [NrHarts-1:0] haltreq_vec,
    output logic [NrHarts-1:0] resumereq_vec
  );
    logic       exists;
    logic [1:0] idx;
    logic       h;
    logic       r;
    logic       u;
    logic       ra;
    logic       hr;
    exists = (hartsel < 10'd4);
    idx    = hartsel[1:0];
    // unavailable hides halted and running
    u  = exists && unavail[idx];
    h  = exists && halted[idx] && !unavail[idx];
    r  = exists && !halted[idx] && !unavail[idx];
    ra = exists && resumeack[idx];
    hr = exists && havereset[idx];
    dmstatus = {12'b0, hr, hr, ra, ra, !exists, !exists, u, u, r, r, h, h,
                1'b1, 3'b0, 4'd2};
    haltsum0 = '0;
    haltsum0[NrHarts-1:0] = halted;
    haltreq_vec   = '0;
    resumereq_vec = '0;
    if (exists) begin
      haltreq_vec[idx]   = haltreq;
      resumereq_vec[idx] = resumereq;
    end
  endfunction

  function automatic logic [31:0] dmcontrol_word(input logic haltreq, input logic resumereq,
                                                 input logic ack, input logic [9:0] hartsel);
    dmcontrol_word = {haltreq, resumereq, 1'b0, ack, 2'b0, hartsel, 14'b0, 1'b0, 1'b1};
  endfunction

  function automatic logic [31:0] abstractcs_word(input logic busy, input logic [2:0] cmderr);
    abstractcs_word = {19'b0, busy, 1'b0, cmderr, 4'b0, 4'd2};
  endfunction

  // --------------------------------------------------
  // dmi access tasks
  // --------------------------------------------------
  task automatic expect_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic send_req(input logic [1:0] op, input logic [DmiAddrWidth-1:0] addr,
                          input logic [31:0] wdata);
    int n;
    n = 0;
    dmi_req_valid_i = 1'b1;
    dmi_req_op_i    = op;
    dmi_req_addr_i  = addr;
    dmi_req_data_i  = wdata;
    while (!dmi_req_ready_o && n < WaitLimit) begin
      idle(1);
      n++;
    end
    if (!dmi_req_ready_o) begin
      errors++;
      $display("ERROR: dmi_req_ready_o stayed low for %0d cycles", n);
    end else begin
      idle(1);
    end
    dmi_req_valid_i = 1'b0;
  endtask

  task automatic wait_resp(output logic [31:0] rdata);
    int n;
    n = 0;
    while (!dmi_resp_valid_o && n < WaitLimit) begin
      idle(1);
      n++;
    end
    if (dmi_resp_valid_o) begin
      rdata = dmi_resp_data_o;
    end else begin
      rdata = '0;
      errors++;
      $display("ERROR: no DMI response within %0d cycles", n);
    end
  endtask

  task automatic dmi_read(input logic [DmiAddrWidth-1:0] addr, output logic [31:0] rdata);
    send_req(DmiOpRead, addr, 32'h0);
    wait_resp(rdata);
  endtask

  task automatic dmi_write(input logic [DmiAddrWidth-1:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    send_req(DmiOpWrite, addr, wdata);
    wait_resp(unused);
  endtask

  task automatic read_check(input string name, input logic [DmiAddrWidth-1:0] addr,
                            input logic [31:0] exp);
    logic [31:0] word;
    dmi_read(addr, word);
    expect_word(name, word, exp);
  endtask

  task automatic write_ctrl(input logic haltreq, input logic resumereq, input logic ack,
                            input logic [9:0] hartsel);
    // ack applies to the hart selected before the write
    if (ack && m_hartsel < 10'd4) begin
      m_havereset[m_hartsel[1:0]] = 1'b0;
    end
    m_hartsel   = hartsel;
    m_haltreq   = haltreq;
    m_resumereq = resumereq;
    dmi_write(AddrDmControl, dmcontrol_word(haltreq, resumereq, ack, hartsel));
  endtask

  task automatic check_status();
    logic [31:0]        exp_status;
    logic [31:0]        exp_sum;
    logic [NrHarts-1:0] exp_halt;
    logic [NrHarts-1:0] exp_resume;
    ref_model(m_hartsel, halted_i, unavailable_i, resumeack_i, m_havereset,
              m_haltreq, m_resumereq, exp_status, exp_sum, exp_halt, exp_resume);
    expect_word("hartsel_o", hartsel_o, m_hartsel);
    expect_word("haltreq_o", haltreq_o, exp_halt);
    expect_word("resumereq_o", resumereq_o, exp_resume);
    read_check("dmi_resp_data_o (dmstatus)", AddrDmStatus, exp_status);
    read_check("dmi_resp_data_o (haltsum0)", AddrHaltSum0, exp_sum);
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin : main_seq
    logic [31:0] word;
    logic [31:0] cmd_word;
    logic [31:0] d0;
    logic [31:0] d1;
    int          n;

    rst_ni           = 1'b0;
    dmi_req_valid_i  = 1'b0;
    dmi_req_addr_i   = '0;
    dmi_req_op_i     = DmiOpNop;
    dmi_req_data_i   = '0;
    dmi_resp_ready_i = 1'b1;
    halted_i         = '0;
    unavailable_i    = '0;
    resumeack_i      = '0;
    cmdbusy_i        = 1'b0;
    cmderror_valid_i = 1'b0;
    cmderror_i       = '0;
    data_i           = '0;
    data_valid_i     = 1'b0;
    errors           = 0;
    checks           = 0;
    clr_pulses       = 0;
    cmd_pulses       = 0;
    m_hartsel        = '0;
    m_havereset      = '1;
    m_haltreq        = 1'b0;
    m_resumereq      = 1'b0;
    void'($urandom(32'he568));

    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    idle(1);

    // reset values
    expect_word("haltreq_o", haltreq_o, 32'h0);
    expect_word("resumereq_o", resumereq_o, 32'h0);
    expect_word("cmd_valid_o", cmd_valid_o, 32'h0);
    expect_word("clear_resumeack_o", clear_resumeack_o, 32'h0);
    expect_word("ndmreset_o", ndmreset_o, 32'h0);
    expect_word("dmactive_o", dmactive_o, 32'h0);
    expect_word("dmi_req_ready_o", dmi_req_ready_o, 32'h1);
    check_status();
    send_req(DmiOpNop, AddrDmStatus, 32'hffff_ffff);
    wait_resp(word);
    expect_word("dmi_resp_data_o (nop)", word, 32'h0);

    // writes other than dmactive are dropped while inactive
    dmi_write(AddrDmControl, 32'h8000_0000);
    expect_word("haltreq_o", haltreq_o, 32'h0);

    // halt requests over all hart selections
    dmi_write(AddrDmControl, 32'h1);
    expect_word("dmactive_o", dmactive_o, 32'h1);
    for (int hs = 0; hs < 6; hs++) begin
      write_ctrl(1'b1, 1'b0, 1'b0, hs[9:0]);
      check_status();
    end
    write_ctrl(1'b0, 1'b0, 1'b0, 10'd0);

    // random hart status
    for (int i = 0; i < 8; i++) begin
      halted_i      = NrHarts'($urandom);
      unavailable_i = NrHarts'($urandom);
      write_ctrl(1'b0, 1'b0, 1'b0, 10'($urandom % 4));
      check_status();
    end
    write_ctrl(1'b0, 1'b0, 1'b0, 10'd2);
    write_ctrl(1'b0, 1'b0, 1'b1, 10'd2);
    for (int j = 0; j < 4; j++) begin
      write_ctrl(1'b0, 1'b0, 1'b0, j[9:0]);
      check_status();
    end

    // resume handshake on hart 1
    halted_i      = '0;
    unavailable_i = '0;
    write_ctrl(1'b0, 1'b0, 1'b0, 10'd1);
    clr_pulses = 0;
    write_ctrl(1'b0, 1'b1, 1'b0, 10'd1);
    expect_word("clear_resumeack_o pulses", clr_pulses, 32'd1);
    expect_word("resumereq_o", resumereq_o, 32'h2);
    resumeack_i = 4'b0010;
    n = 0;
    while (resumereq_o != '0 && n < WaitLimit) begin
      idle(1);
      n++;
    end
    if (resumereq_o != '0) begin
      errors++;
      $display("ERROR: resumereq_o was not released after resumeack_i");
    end
    expect_word("resumereq_o release cycles", n, 32'd1);
    m_resumereq = 1'b0;
    check_status();
    resumeack_i = '0;

    // abstract command
    cmd_word   = $urandom;
    cmd_pulses = 0;
    dmi_write(AddrCommand, cmd_word);
    idle(2);
    expect_word("cmd_valid_o pulses", cmd_pulses, 32'd1);
    expect_word("cmd_o", cmd_o, cmd_word);
    cmdbusy_i  = 1'b1;
    cmd_pulses = 0;
    dmi_write(AddrCommand, ~cmd_word);
    idle(2);
    expect_word("cmd_valid_o pulses", cmd_pulses, 32'd0);
    expect_word("cmd_o", cmd_o, cmd_word);
    read_check("dmi_resp_data_o (abstractcs)", AddrAbstractCs, abstractcs_word(1'b1, 3'd1));
    // clear is ignored while busy
    dmi_write(AddrAbstractCs, 32'h700);
    read_check("dmi_resp_data_o (abstractcs)", AddrAbstractCs, abstractcs_word(1'b1, 3'd1));
    cmdbusy_i = 1'b0;
    dmi_write(AddrAbstractCs, 32'h700);
    read_check("dmi_resp_data_o (abstractcs)", AddrAbstractCs, abstractcs_word(1'b0, 3'd0));
    cmderror_i       = 3'd3;
    cmderror_valid_i = 1'b1;
    idle(1);
    cmderror_valid_i = 1'b0;
    read_check("dmi_resp_data_o (abstractcs)", AddrAbstractCs, abstractcs_word(1'b0, 3'd3));
    dmi_write(AddrAbstractCs, 32'h700);
    read_check("dmi_resp_data_o (abstractcs)", AddrAbstractCs, abstractcs_word(1'b0, 3'd0));

    // data registers and autoexec
    d0 = $urandom;
    d1 = $urandom;
    dmi_write(AddrData0, d0);
    dmi_write(AddrData0 + 7'd1, d1);
    read_check("dmi_resp_data_o (data0)", AddrData0, d0);
    read_check("dmi_resp_data_o (data1)", AddrData0 + 7'd1, d1);
    expect_word("data_o[0]", data_o[0], d0);
    expect_word("data_o[1]", data_o[1], d1);
    dmi_write(AddrAbstractAuto, 32'h1);
    read_check("dmi_resp_data_o (abstractauto)", AddrAbstractAuto, 32'h1);
    cmd_pulses = 0;
    dmi_read(AddrData0, word);
    dmi_write(AddrData0 + 7'd1, d1);
    dmi_write(AddrData0, d0);
    idle(2);
    expect_word("cmd_valid_o pulses", cmd_pulses, 32'd2);
    dmi_write(AddrAbstractAuto, 32'h0);
    d0           = $urandom;
    d1           = $urandom;
    data_i[0]    = d0;
    data_i[1]    = d1;
    data_valid_i = 1'b1;
    idle(1);
    data_valid_i = 1'b0;
    read_check("dmi_resp_data_o (data0)", AddrData0, d0);
    read_check("dmi_resp_data_o (data1)", AddrData0 + 7'd1, d1);

    // response back-pressure
    halted_i = 4'ha;
    idle(1);
    dmi_resp_ready_i = 1'b0;
    send_req(DmiOpRead, AddrData0, 32'h0);
    send_req(DmiOpRead, AddrData0 + 7'd1, 32'h0);
    expect_word("dmi_req_ready_o", dmi_req_ready_o, 32'h0);
    dmi_req_valid_i = 1'b1;
    dmi_req_op_i    = DmiOpRead;
    dmi_req_addr_i  = AddrHaltSum0;
    idle(3);
    expect_word("dmi_req_ready_o", dmi_req_ready_o, 32'h0);
    expect_word("dmi_resp_valid_o", dmi_resp_valid_o, 32'h1);
    dmi_resp_ready_i = 1'b1;
    fork
      send_req(DmiOpRead, AddrHaltSum0, 32'h0);
      begin : collect_resps
        for (int k = 0; k < 3; k++) begin
          n = 0;
          while (!dmi_resp_valid_o && n < WaitLimit) begin
            idle(1);
            n++;
          end
          if (dmi_resp_valid_o) begin
            resp_q.push_back(dmi_resp_data_o);
            idle(1);
          end else begin
            errors++;
            $display("ERROR: queued response %0d never came out", k);
          end
        end
      end
    join
    if (resp_q.size() == 3) begin
      expect_word("dmi_resp_data_o (queued 0)", resp_q[0], d0);
      expect_word("dmi_resp_data_o (queued 1)", resp_q[1], d1);
      expect_word("dmi_resp_data_o (queued 2)", resp_q[2], 32'ha);
    end

    n = 0;
    while (got_q.size() > 0 && n < WaitLimit) begin
      idle(1);
      n++;
    end
    idle(1);
    errors += i_dut.i_sva.fail_count;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dm_debug_regs.f ====
verilog/dm_pkg.sv
verilog/dm_csr_if.sv
verilog/dm_dmi_front.sv
verilog/dm_hart_ctrl.sv
verilog/dm_abstract_cmd.sv
verilog/dm_top.sv
tb/dm_top_sva.sv
tb/tb_dm_top.sv

// ==== Bender.yml ====
package:
  name: dm_debug_regs

sources:
  - verilog/dm_pkg.sv
  - verilog/dm_csr_if.sv
  - verilog/dm_dmi_front.sv
  - verilog/dm_hart_ctrl.sv
  - verilog/dm_abstract_cmd.sv
  - verilog/dm_top.sv
  - target: simulation
    files:
      - tb/dm_top_sva.sv
      - tb/tb_dm_top.sv
